/* hw/core_pkg.sv */
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // one value per supported instruction
  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
    OP_LUI, OP_AUIPC,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_JAL, OP_JALR,
    OP_LW, OP_SW
  } op_e;

  typedef enum logic [2:0] {
    ST_IDLE, ST_FETCH, ST_DECODE, ST_EXECUTE, ST_MEMORY, ST_WRITEBACK
  } stage_e;

  typedef struct packed {
    word_t result;
    word_t store_data;
    word_t next_pc;
    logic  write_rd;
  } exec_res_t;

  // major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // funct3, alu group
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3, branches and word access
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;
  localparam logic [2:0] F3_W    = 3'b010;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

/* hw/decoded_if.sv */
`timescale 1ns/1ns

// one decoded instruction, held from decode until the next decode
interface decoded_if import core_pkg::*; ();

  op_e      op;
  reg_idx_t rd;
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    imm;
  word_t    pc;

  modport producer (
    output op,
    output rd,
    output rs1_val,
    output rs2_val,
    output imm,
    output pc
  );

  modport consumer (
    input op,
    input rd,
    input rs1_val,
    input rs2_val,
    input imm,
    input pc
  );

endinterface

/* hw/core_fetch.sv */
`timescale 1ns/1ns

module core_fetch import core_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic      CLK,
  input  logic      RST_N,
  input  word_t     i_imem_data,
  input  exec_res_t i_res,
  output word_t     o_imem_addr,
  output word_t     o_pc,
  output word_t     o_instr,
  output stage_e    o_stage
);

  word_t  pc_q;
  word_t  instr_q;
  stage_e stage_q;

  // one cycle per stage, no stalls
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      stage_q <= ST_IDLE;
    end else begin
      case (stage_q)
        ST_IDLE:      stage_q <= ST_FETCH;
        ST_FETCH:     stage_q <= ST_DECODE;
        ST_DECODE:    stage_q <= ST_EXECUTE;
        ST_EXECUTE:   stage_q <= ST_MEMORY;
        ST_MEMORY:    stage_q <= ST_WRITEBACK;
        default:      stage_q <= ST_FETCH;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      pc_q <= RESET_PC;
    end else if (stage_q == ST_WRITEBACK) begin
      pc_q <= i_res.next_pc;
    end
  end

  always_ff @(posedge CLK) begin
    if (stage_q == ST_FETCH) begin
      instr_q <= i_imem_data;
    end
  end

  // instruction memory is word addressed
  assign o_imem_addr = {2'b00, pc_q[31:2]};
  assign o_pc        = pc_q;
  assign o_instr     = instr_q;
  assign o_stage     = stage_q;

endmodule

/* hw/core_decode.sv */
`timescale 1ns/1ns

module core_decode import core_pkg::*; (
  input  logic     CLK,
  input  logic     RST_N,
  input  stage_e   i_stage,
  input  word_t    i_instr,
  input  word_t    i_pc,
  output reg_idx_t o_rs1_idx,
  output reg_idx_t o_rs2_idx,
  input  word_t    i_rs1_val,
  input  word_t    i_rs2_val,
  decoded_if.producer dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd_f;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  op_e        op_next;
  reg_idx_t   rd_next;
  word_t      imm_next;

  assign opcode = i_instr[6:0];
  assign funct3 = i_instr[14:12];
  assign funct7 = i_instr[31:25];
  assign rd_f   = i_instr[11:7];

  assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
  assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
  assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                  i_instr[11:8], 1'b0};
  assign imm_u = {i_instr[31:12], 12'b0};
  assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                  i_instr[30:21], 1'b0};

  assign o_rs1_idx = i_instr[19:15];
  assign o_rs2_idx = i_instr[24:20];

  // anything unrecognised stays addi x0, a no-op
  always_comb begin
    op_next  = OP_ADDI;
    rd_next  = '0;
    imm_next = imm_i;
    case (opcode)
      OPC_LUI: begin
        op_next  = OP_LUI;
        rd_next  = rd_f;
        imm_next = imm_u;
      end
      OPC_AUIPC: begin
        op_next  = OP_AUIPC;
        rd_next  = rd_f;
        imm_next = imm_u;
      end
      OPC_JAL: begin
        op_next  = OP_JAL;
        rd_next  = rd_f;
        imm_next = imm_j;
      end
      OPC_JALR: begin
        op_next = OP_JALR;
        rd_next = rd_f;
      end
      OPC_BRANCH: begin
        imm_next = imm_b;
        case (funct3)
          F3_BEQ:  op_next = OP_BEQ;
          F3_BNE:  op_next = OP_BNE;
          F3_BLT:  op_next = OP_BLT;
          F3_BGE:  op_next = OP_BGE;
          F3_BLTU: op_next = OP_BLTU;
          F3_BGEU: op_next = OP_BGEU;
          default: op_next = OP_ADDI;
        endcase
      end
      OPC_LOAD: begin
        if (funct3 == F3_W) begin
          op_next = OP_LW;
          rd_next = rd_f;
        end
      end
      OPC_STORE: begin
        if (funct3 == F3_W) begin
          op_next  = OP_SW;
          imm_next = imm_s;
        end
      end
      OPC_OP_IMM: begin
        rd_next = rd_f;
        case (funct3)
          F3_ADD_SUB: op_next = OP_ADDI;
          F3_SLL:     op_next = OP_SLLI;
          F3_SLT:     op_next = OP_SLTI;
          F3_SLTU:    op_next = OP_SLTIU;
          F3_XOR:     op_next = OP_XORI;
          F3_SR:      op_next = (funct7 == F7_ALT) ? OP_SRAI : OP_SRLI;
          F3_OR:      op_next = OP_ORI;
          default:    op_next = OP_ANDI;
        endcase
      end
      OPC_OP: begin
        // other funct7 values belong to extensions we lack
        if (funct7 == F7_BASE || funct7 == F7_ALT) begin
          rd_next = rd_f;
          case (funct3)
            F3_ADD_SUB: op_next = (funct7 == F7_ALT) ? OP_SUB : OP_ADD;
            F3_SLL:     op_next = OP_SLL;
            F3_SLT:     op_next = OP_SLT;
            F3_SLTU:    op_next = OP_SLTU;
            F3_XOR:     op_next = OP_XOR;
            F3_SR:      op_next = (funct7 == F7_ALT) ? OP_SRA : OP_SRL;
            F3_OR:      op_next = OP_OR;
            default:    op_next = OP_AND;
          endcase
        end
      end
      default: begin
        op_next = OP_ADDI;
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      dec.op <= OP_ADDI;
      dec.rd <= '0;
    end else if (i_stage == ST_DECODE) begin
      dec.op <= op_next;
      dec.rd <= rd_next;
    end
  end

  always_ff @(posedge CLK) begin
    if (i_stage == ST_DECODE) begin
      dec.rs1_val <= i_rs1_val;
      dec.rs2_val <= i_rs2_val;
      dec.imm     <= imm_next;
      dec.pc      <= i_pc;
    end
  end

endmodule

/* hw/core_regfile.sv */
`timescale 1ns/1ns

module core_regfile import core_pkg::*; (
  input  logic     CLK,
  input  logic     RST_N,
  input  reg_idx_t i_rs1_idx,
  input  reg_idx_t i_rs2_idx,
  output word_t    o_rs1_val,
  output word_t    o_rs2_val,
  input  reg_idx_t i_rd_idx,
  input  word_t    i_rd_val,
  input  logic     i_we
);

  word_t regs [32];

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd_idx != '0) begin
      regs[i_rd_idx] <= i_rd_val;
    end
  end

  // x0 is hardwired
  assign o_rs1_val = (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx];
  assign o_rs2_val = (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx];

endmodule

/* hw/core_execute.sv */
`timescale 1ns/1ns

module core_execute import core_pkg::*; (
  input  logic      CLK,
  input  logic      RST_N,
  input  stage_e    i_stage,
  decoded_if.consumer dec,
  output exec_res_t o_res
);

  word_t     op_b;
  word_t     alu;
  word_t     pc_plus4;
  word_t     jalr_target;
  logic      lt_s;
  logic      lt_u;
  logic      taken;
  exec_res_t res_next;

  // register-register ops use rs2, everything else the immediate
  always_comb begin
    case (dec.op)
      OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
      OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND: op_b = dec.rs2_val;
      default:                               op_b = dec.imm;
    endcase
  end

  assign pc_plus4    = dec.pc + 32'd4;
  assign jalr_target = (dec.rs1_val + dec.imm) & ~32'd1;
  assign lt_s        = $signed(dec.rs1_val) < $signed(op_b);
  assign lt_u        = dec.rs1_val < op_b;

  always_comb begin
    case (dec.op)
      OP_ADD, OP_ADDI, OP_LW, OP_SW: alu = dec.rs1_val + op_b;
      OP_SUB:                        alu = dec.rs1_val - op_b;
      OP_SLL, OP_SLLI:               alu = dec.rs1_val << op_b[4:0];
      OP_SRL, OP_SRLI:               alu = dec.rs1_val >> op_b[4:0];
      OP_SRA, OP_SRAI:               alu = $signed(dec.rs1_val) >>> op_b[4:0];
      OP_SLT, OP_SLTI:               alu = {31'b0, lt_s};
      OP_SLTU, OP_SLTIU:             alu = {31'b0, lt_u};
      OP_XOR, OP_XORI:               alu = dec.rs1_val ^ op_b;
      OP_OR, OP_ORI:                 alu = dec.rs1_val | op_b;
      OP_AND, OP_ANDI:               alu = dec.rs1_val & op_b;
      OP_LUI:                        alu = dec.imm;
      OP_AUIPC:                      alu = dec.pc + dec.imm;
      OP_JAL, OP_JALR:               alu = pc_plus4;
      default:                       alu = '0;
    endcase
  end

  // branches compare against rs2, so op_b is not used here
  always_comb begin
    case (dec.op)
      OP_BEQ:  taken = dec.rs1_val == dec.rs2_val;
      OP_BNE:  taken = dec.rs1_val != dec.rs2_val;
      OP_BLT:  taken = $signed(dec.rs1_val) < $signed(dec.rs2_val);
      OP_BGE:  taken = $signed(dec.rs1_val) >= $signed(dec.rs2_val);
      OP_BLTU: taken = dec.rs1_val < dec.rs2_val;
      OP_BGEU: taken = dec.rs1_val >= dec.rs2_val;
      OP_JAL:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    res_next.result     = alu;
    res_next.store_data = dec.rs2_val;
    if (dec.op == OP_JALR) begin
      res_next.next_pc = jalr_target;
    end else if (taken) begin
      res_next.next_pc = dec.pc + dec.imm;
    end else begin
      res_next.next_pc = pc_plus4;
    end
    case (dec.op)
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_SW: res_next.write_rd = 1'b0;
      default:                                                  res_next.write_rd = 1'b1;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      o_res.write_rd <= 1'b0;
    end else if (i_stage == ST_EXECUTE) begin
      o_res <= res_next;
    end
  end

endmodule

/* hw/core_writeback.sv */
`timescale 1ns/1ns

module core_writeback import core_pkg::*; (
  input  logic      CLK,
  input  logic      RST_N,
  input  stage_e    i_stage,
  input  op_e       i_op,
  input  reg_idx_t  i_rd,
  input  exec_res_t i_res,
  input  word_t     i_dmem_rdata,
  output word_t     o_dmem_addr,
  output word_t     o_dmem_wdata,
  output logic      o_dmem_we,
  output reg_idx_t  o_rd_idx,
  output word_t     o_rd_val,
  output logic      o_rd_we
);

  word_t load_q;

  // data memory answers in the same cycle
  assign o_dmem_addr  = i_res.result;
  assign o_dmem_wdata = i_res.store_data;
  assign o_dmem_we    = (i_stage == ST_MEMORY) && (i_op == OP_SW);

  // load word sampled at the end of memory
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      load_q <= '0;
    end else if (i_stage == ST_MEMORY) begin
      load_q <= i_dmem_rdata;
    end
  end

  assign o_rd_idx = i_rd;
  assign o_rd_val = (i_op == OP_LW) ? load_q : i_res.result;
  assign o_rd_we  = (i_stage == ST_WRITEBACK) && i_res.write_rd;

endmodule

/* hw/core_top.sv */
`timescale 1ns/1ns

module core_top import core_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic  CLK,
  input  logic  RST_N,
  input  word_t i_imem_data,
  output word_t o_imem_addr,
  input  word_t i_dmem_rdata,
  output word_t o_dmem_addr,
  output word_t o_dmem_wdata,
  output logic  o_dmem_we
);

  stage_e    stage;
  word_t     pc;
  word_t     instr;
  exec_res_t res;
  reg_idx_t  rs1_idx;
  reg_idx_t  rs2_idx;
  word_t     rs1_val;
  word_t     rs2_val;
  reg_idx_t  rd_idx;
  word_t     rd_val;
  logic      rd_we;

  decoded_if dec_bus ();

  core_fetch #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .CLK         (CLK),
    .RST_N       (RST_N),
    .i_imem_data (i_imem_data),
    .i_res       (res),
    .o_imem_addr (o_imem_addr),
    .o_pc        (pc),
    .o_instr     (instr),
    .o_stage     (stage)
  );

  core_decode u_decode (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .i_stage   (stage),
    .i_instr   (instr),
    .i_pc      (pc),
    .o_rs1_idx (rs1_idx),
    .o_rs2_idx (rs2_idx),
    .i_rs1_val (rs1_val),
    .i_rs2_val (rs2_val),
    .dec       (dec_bus.producer)
  );

  core_regfile u_regfile (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .i_rs1_idx (rs1_idx),
    .i_rs2_idx (rs2_idx),
    .o_rs1_val (rs1_val),
    .o_rs2_val (rs2_val),
    .i_rd_idx  (rd_idx),
    .i_rd_val  (rd_val),
    .i_we      (rd_we)
  );

  core_execute u_execute (
    .CLK     (CLK),
    .RST_N   (RST_N),
    .i_stage (stage),
    .dec     (dec_bus.consumer),
    .o_res   (res)
  );

  core_writeback u_writeback (
    .CLK          (CLK),
    .RST_N        (RST_N),
    .i_stage      (stage),
    .i_op         (dec_bus.op),
    .i_rd         (dec_bus.rd),
    .i_res        (res),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_we    (o_dmem_we),
    .o_rd_idx     (rd_idx),
    .o_rd_val     (rd_val),
    .o_rd_we      (rd_we)
  );

endmodule

/* bench/core_tb.sv */
`timescale 1ns/1ns

module core_tb import core_pkg::*; ();

  localparam word_t RESET_PC   = 32'h0000_0100;
  localparam int    IMEM_BASE  = 64;
  // six tests take about 1800 cycles
  localparam int    MAX_CYCLES = 3000;
  localparam word_t MSB        = 32'h8000_0000;

  logic  CLK = 1'b0;
  logic  RST_N;
  word_t imem_data;
  word_t imem_addr;
  word_t dmem_rdata;
  word_t dmem_addr;
  word_t dmem_wdata;
  logic  dmem_we;

  word_t imem [512];
  word_t dmem [256];
  word_t exp_addr [$];
  word_t exp_data [$];
  word_t got_addr [$];
  word_t got_data [$];
  int    seed;
  int    cycles = 0;
  int    prog_len;
  word_t out_off;
  string test_name;

  core_top #(
    .RESET_PC (RESET_PC)
  ) DUT (
    .CLK          (CLK),
    .RST_N        (RST_N),
    .i_imem_data  (imem_data),
    .o_imem_addr  (imem_addr),
    .i_dmem_rdata (dmem_rdata),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .o_dmem_we    (dmem_we)
  );

  always #5 CLK = ~CLK;

  // both memories answer in the same cycle
  assign imem_data  = imem[imem_addr[8:0]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      stop_run($sformatf("timeout: tests still running after %0d cycles", MAX_CYCLES));
    end
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string msg);
    if (got !== exp) begin
      stop_run($sformatf("ERR %0t %s: got %h, expected %h", $time, msg, got, exp));
    end
  endtask

  task automatic check_addr(input word_t got, input word_t exp, input string msg);
    if (got !== exp) begin
      stop_run($sformatf("ERR %0t %s: address %h, expected %h", $time, msg, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      stop_run($sformatf("ERR %0t %s: got %b, expected %b", $time, msg, got, exp));
    end
  endtask

  // instruction encoders
  function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3,
                                  input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd,
                                  input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                  input reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, F3_W, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                  input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic word_t enc_j(input logic [20:0] off, input reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // RV32I reference results
  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    word_t r;
    case (f3)
      3'b000: r = alt ? a - b : a + b;
      3'b001: r = a << b[4:0];
      3'b010: r = {31'b0, $signed(a) < $signed(b)};
      3'b011: r = {31'b0, a < b};
      3'b100: r = a ^ b;
      3'b101: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'b110: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic word_t here_pc();
    return RESET_PC + 32'(4 * prog_len);
  endfunction

  // unused slots hold addi x0 no-ops
  task automatic fill_memories();
    for (int i = 0; i < 512; i++) begin
      imem[9'(i)] = enc_i(12'(i), 5'd0, F3_ADD_SUB, 5'd0, OPC_OP_IMM);
    end
    for (int i = 0; i < 256; i++) begin
      dmem[8'(i)] = {16'hd00d, 8'(i), ~8'(i)};
    end
  endtask

  task automatic emit(input word_t instr);
    imem[9'(IMEM_BASE + prog_len)] = instr;
    prog_len++;
  endtask

  task automatic load_imm(input reg_idx_t rd, input word_t v);
    word_t hi;
    hi = v + 32'h800;
    emit(enc_u(hi[31:12], rd, OPC_LUI));
    emit(enc_i(v[11:0], rd, F3_ADD_SUB, rd, OPC_OP_IMM));
  endtask

  task automatic set_small(input reg_idx_t rd, input logic [11:0] v);
    emit(enc_i(v, 5'd0, F3_ADD_SUB, rd, OPC_OP_IMM));
  endtask

  task automatic expect_store(input word_t data);
    exp_addr.push_back(out_off);
    exp_data.push_back(data);
    out_off += 4;
  endtask

  task automatic store_reg(input reg_idx_t rs, input word_t data);
    emit(enc_s(out_off[11:0], rs, 5'd0));
    expect_store(data);
  endtask

  // reset goes low here and stays low while the program is loaded
  task automatic begin_test(input string name);
    @(posedge CLK);
    #1 RST_N = 1'b0;
    test_name = name;
    prog_len  = 0;
    out_off   = 32'h100;
    exp_addr.delete();
    exp_data.delete();
    got_addr.delete();
    got_data.delete();
    fill_memories();
  endtask

  // one clock, with any store written into data memory at the falling edge
  task automatic step_cycle();
    @(negedge CLK);
    if (dmem_we === 1'b1) begin
      dmem[dmem_addr[9:2]] = dmem_wdata;
      got_addr.push_back(dmem_addr);
      got_data.push_back(dmem_wdata);
    end
  endtask

  task automatic hold_reset();
    repeat (5) begin
      @(negedge CLK);
      check_flag(dmem_we, 1'b0, "store enable during reset");
    end
    @(posedge CLK);
    #1 RST_N = 1'b1;
  endtask

  task automatic check_stores();
    if (got_addr.size() != exp_addr.size()) begin
      stop_run($sformatf("%s: %0d stores seen, %0d expected", test_name,
                         got_addr.size(), exp_addr.size()));
    end
    for (int i = 0; i < exp_addr.size(); i++) begin
      check_addr(got_addr[i], exp_addr[i], $sformatf("%s store %0d", test_name, i));
      check_word(got_data[i], exp_data[i], $sformatf("%s store %0d", test_name, i));
    end
  endtask

  // self-jump at the end, then idle plus five cycles per instruction
  task automatic run_program();
    emit(enc_j(21'd0, 5'd0));
    hold_reset();
    repeat (1 + 5 * prog_len) step_cycle();
    check_stores();
  endtask

  task automatic test_reset();
    begin_test("reset");
    emit(enc_j(21'd0, 5'd0));
    hold_reset();
    step_cycle();
    check_flag(dmem_we, 1'b0, "store enable in idle");
    step_cycle();
    check_addr(imem_addr, RESET_PC >> 2, "first fetch");
    check_flag(dmem_we, 1'b0, "store enable in first fetch");
  endtask

  task automatic test_alu();
    word_t       a;
    word_t       b;
    word_t       r;
    logic [11:0] imm;
    logic [4:0]  sh;
    logic [2:0]  f3;
    begin_test("alu");
    for (int p = 0; p < 3; p++) begin
      a   = $random(seed);
      b   = $random(seed);
      r   = $random(seed);
      imm = r[11:0];
      sh  = b[4:0];
      load_imm(5'd1, a);
      load_imm(5'd2, b);
      for (int k = 0; k < 8; k++) begin
        f3 = 3'(k);
        emit(enc_r(F7_BASE, 5'd2, 5'd1, f3, 5'd3));
        store_reg(5'd3, alu_ref(f3, 1'b0, a, b));
        if (f3 == F3_ADD_SUB || f3 == F3_SR) begin
          emit(enc_r(F7_ALT, 5'd2, 5'd1, f3, 5'd3));
          store_reg(5'd3, alu_ref(f3, 1'b1, a, b));
        end
        if (f3 == F3_SLL || f3 == F3_SR) begin
          emit(enc_i({F7_BASE, sh}, 5'd1, f3, 5'd4, OPC_OP_IMM));
          store_reg(5'd4, alu_ref(f3, 1'b0, a, {27'b0, sh}));
        end else begin
          emit(enc_i(imm, 5'd1, f3, 5'd4, OPC_OP_IMM));
          store_reg(5'd4, alu_ref(f3, 1'b0, a, {{20{imm[11]}}, imm}));
        end
        if (f3 == F3_SR) begin
          emit(enc_i({F7_ALT, sh}, 5'd1, f3, 5'd4, OPC_OP_IMM));
          store_reg(5'd4, alu_ref(f3, 1'b1, a, {27'b0, sh}));
        end
      end
    end
    run_program();
  endtask

  task automatic test_upper();
    word_t       r;
    word_t       pc;
    logic [19:0] u;
    begin_test("lui/auipc");
    for (int k = 0; k < 2; k++) begin
      r = $random(seed);
      u = r[19:0];
      emit(enc_u(u, 5'd3, OPC_LUI));
      store_reg(5'd3, {u, 12'b0});
      r  = $random(seed);
      u  = r[19:0];
      pc = here_pc();
      emit(enc_u(u, 5'd4, OPC_AUIPC));
      store_reg(5'd4, pc + {u, 12'b0});
    end
    run_program();
  endtask

  // marker 1 on fall-through, marker 2 at the target, same slot
  task automatic test_branch();
    word_t      r1;
    word_t      r2;
    word_t      a;
    word_t      b;
    logic [2:0] f3;
    begin_test("branch");
    for (int k = 0; k < 8; k++) begin
      f3 = 3'(k);
      if (f3 != 3'b010 && f3 != 3'b011) begin
        for (int c = 0; c < 3; c++) begin
          r1 = $random(seed);
          r2 = $random(seed);
          case (c)
            0: begin
              a = r1;
              b = r1;
            end
            1: begin
              a = r1 | MSB;
              b = r2 & ~MSB;
            end
            default: begin
              a = r2 & ~MSB;
              b = r1 | MSB;
            end
          endcase
          load_imm(5'd1, a);
          load_imm(5'd2, b);
          emit(enc_b(13'd16, 5'd2, 5'd1, f3));
          set_small(5'd5, 12'd1);
          emit(enc_s(out_off[11:0], 5'd5, 5'd0));
          emit(enc_j(21'd12, 5'd0));
          set_small(5'd5, 12'd2);
          emit(enc_s(out_off[11:0], 5'd5, 5'd0));
          expect_store(branch_ref(f3, a, b) ? 32'd2 : 32'd1);
        end
      end
    end
    run_program();
  endtask

  task automatic test_jump();
    word_t pc_j;
    word_t pc_a;
    begin_test("jal/jalr");
    pc_j = here_pc();
    emit(enc_j(21'd12, 5'd1));
    set_small(5'd5, 12'd1);
    emit(enc_s(out_off[11:0], 5'd5, 5'd0));
    set_small(5'd5, 12'd2);
    emit(enc_s(out_off[11:0], 5'd5, 5'd0));
    expect_store(32'd2);
    store_reg(5'd1, pc_j + 32'd4);
    pc_a = here_pc();
    emit(enc_u(20'd0, 5'd6, OPC_AUIPC));
    // odd offset, target lands on pc_a + 16 once bit 0 is cleared
    emit(enc_i(12'd17, 5'd6, 3'b000, 5'd7, OPC_JALR));
    set_small(5'd5, 12'd1);
    emit(enc_s(out_off[11:0], 5'd5, 5'd0));
    set_small(5'd5, 12'd2);
    emit(enc_s(out_off[11:0], 5'd5, 5'd0));
    expect_store(32'd2);
    store_reg(5'd7, pc_a + 32'd8);
    run_program();
  endtask

  task automatic test_load();
    word_t addr;
    word_t val;
    begin_test("lw");
    for (int k = 0; k < 4; k++) begin
      addr = 32'h40 + 32'(8 * k);
      val  = $random(seed);
      dmem[addr[9:2]] = val;
      emit(enc_i(addr[11:0], 5'd0, F3_W, 5'd8, OPC_LOAD));
      store_reg(5'd8, val);
    end
    // x0 keeps reading zero after writes
    set_small(5'd0, 12'h123);
    emit(enc_u(20'habcde, 5'd0, OPC_LUI));
    store_reg(5'd0, 32'd0);
    run_program();
  endtask

  initial begin
    RST_N    = 1'b0;
    seed     = 55392;
    prog_len = 0;
    out_off  = '0;
    fill_memories();
    test_reset();
    test_alu();
    test_upper();
    test_branch();
    test_jump();
    test_load();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* sources.f */
hw/core_pkg.sv
hw/decoded_if.sv
hw/core_fetch.sv
hw/core_decode.sv
hw/core_regfile.sv
hw/core_execute.sv
hw/core_writeback.sv
hw/core_top.sv
bench/core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns --top-module core_tb \
  -f sources.f --Mdir obj_dir -o core_tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/core_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
exit 0
